//--- logic/graphics_pkg.sv
package graphics_pkg;

    // Visible frame and full scan
    localparam int frame_width = 16;
    localparam int frame_height = 8;
    localparam int line_total = 20;
    localparam int frame_total_lines = 10;
    localparam int pixel_count = 128;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] operand_count_t;
    typedef logic [7:0] coord_t;
    typedef logic [3:0] pixel_index_t;

    // Row times 16 plus column
    typedef logic [6:0] pixel_address_t;

    localparam byte_t op_assign_color = 8'h11;
    localparam byte_t op_draw_sprite = 8'h12;
    localparam byte_t op_switch_buffer = 8'h14;

    typedef struct packed {
        logic [3:0] y;
        logic [2:0] cb;
        logic [2:0] cr;
    } yuv_color_t;

    typedef struct packed {
        logic enable;
        pixel_index_t index;
        yuv_color_t color;
    } palette_write_t;

    typedef struct packed {
        logic enable;
        pixel_address_t address;
        pixel_index_t index;
    } pixel_write_t;

    // bits_per_pixel holds log2 of the pixel width: 0, 1 or 2
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t width;
        logic [1:0] bits_per_pixel;
        pixel_index_t palette_offset;
    } sprite_config_t;

endpackage

//--- logic/command_decoder.sv
`timescale 1ns/100ps

module command_decoder (
    input logic display_clock_in,
    input logic display_reset_n_in,
    input graphics_pkg::byte_t op_code_in,
    input logic op_code_valid_in,
    input graphics_pkg::byte_t operand_in,
    input logic operand_valid_in,
    input graphics_pkg::operand_count_t operand_count_in,
    output graphics_pkg::palette_write_t palette_write,
    output graphics_pkg::sprite_config_t sprite_config,
    output logic sprite_start,
    output graphics_pkg::byte_t sprite_data,
    output logic sprite_data_valid,
    output logic swap_request
);

    logic op_code_valid_q;
    logic assign_strobe;
    logic sprite_strobe;
    logic palette_enable;
    graphics_pkg::pixel_index_t palette_index;
    graphics_pkg::yuv_color_t palette_color;
    logic [1:0] bpp_code;

    assign assign_strobe = op_code_valid_in && operand_valid_in &&
                           op_code_in == graphics_pkg::op_assign_color;
    assign sprite_strobe = op_code_valid_in && operand_valid_in &&
                           op_code_in == graphics_pkg::op_draw_sprite;

    // Color count to pixel width
    always_comb begin
        case (operand_in)
            8'd4: bpp_code = 2'd1;
            8'd16: bpp_code = 2'd2;
            default: bpp_code = 2'd0;
        endcase
    end

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            op_code_valid_q <= 1'b0;
            palette_enable <= 1'b0;
            sprite_start <= 1'b0;
            sprite_data_valid <= 1'b0;
            swap_request <= 1'b0;
        end else begin
            op_code_valid_q <= op_code_valid_in;
            palette_enable <= assign_strobe && operand_count_in == 8'd4;
            sprite_start <= sprite_strobe && operand_count_in == 8'd5;
            sprite_data_valid <= sprite_strobe && operand_count_in > 8'd5;
            swap_request <= op_code_valid_in && !op_code_valid_q &&
                            op_code_in == graphics_pkg::op_switch_buffer;
        end
    end

    // Partial palette entry and sprite setup, held across strobes
    always_ff @(posedge display_clock_in) begin
        if (assign_strobe) begin
            case (operand_count_in)
                8'd1: palette_index <= operand_in[3:0];
                8'd2: palette_color.y <= operand_in[7:4];
                8'd3: palette_color.cb <= operand_in[7:5];
                8'd4: palette_color.cr <= operand_in[7:5];
                default: ;
            endcase
        end
        if (sprite_strobe) begin
            case (operand_count_in)
                8'd1: sprite_config.x <= operand_in;
                8'd2: sprite_config.y <= operand_in;
                8'd3: sprite_config.width <= operand_in;
                8'd4: sprite_config.bits_per_pixel <= bpp_code;
                8'd5: sprite_config.palette_offset <= operand_in[3:0];
                default: ;
            endcase
        end
        if (sprite_strobe && operand_count_in > 8'd5) begin
            sprite_data <= operand_in;
        end
    end

    assign palette_write = '{enable: palette_enable, index: palette_index, color: palette_color};

    operand_inside_command: assert property (
        @(posedge display_clock_in) disable iff (!display_reset_n_in)
        operand_valid_in |-> op_code_valid_in
    );

endmodule

//--- logic/sprite_engine.sv
`timescale 1ns/100ps

module sprite_engine (
    input logic display_clock_in,
    input logic display_reset_n_in,
    input graphics_pkg::sprite_config_t sprite_config,
    input logic sprite_start,
    input graphics_pkg::byte_t sprite_data,
    input logic sprite_data_valid,
    output graphics_pkg::pixel_write_t pixel_write,
    output logic busy
);

    graphics_pkg::byte_t data_shift;
    logic [3:0] remaining;
    graphics_pkg::coord_t cursor_x;
    graphics_pkg::coord_t cursor_y;
    graphics_pkg::pixel_index_t raw;
    logic [3:0] step;
    logic last_column;
    logic in_frame;

    assign busy = remaining != 4'd0;
    assign step = 4'd1 << sprite_config.bits_per_pixel;
    assign last_column = cursor_x == sprite_config.x + sprite_config.width - 8'd1;
    assign in_frame = cursor_x < graphics_pkg::coord_t'(graphics_pkg::frame_width) &&
                      cursor_y < graphics_pkg::coord_t'(graphics_pkg::frame_height);

    // Top bits of the byte are the next pixel
    always_comb begin
        case (sprite_config.bits_per_pixel)
            2'd1: raw = {2'b00, data_shift[7:6]};
            2'd2: raw = data_shift[7:4];
            default: raw = {3'b000, data_shift[7]};
        endcase
    end

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            remaining <= 4'd0;
            cursor_x <= '0;
            cursor_y <= '0;
        end else begin
            if (sprite_data_valid) begin
                remaining <= 4'd8 >> sprite_config.bits_per_pixel;
            end else if (busy) begin
                remaining <= remaining - 4'd1;
            end
            if (sprite_start) begin
                cursor_x <= sprite_config.x;
                cursor_y <= sprite_config.y;
            end else if (busy && last_column) begin
                cursor_x <= sprite_config.x;
                cursor_y <= cursor_y + 8'd1;
            end else if (busy) begin
                cursor_x <= cursor_x + 8'd1;
            end
        end
    end

    always_ff @(posedge display_clock_in) begin
        if (sprite_data_valid) begin
            data_shift <= sprite_data;
        end else if (busy) begin
            data_shift <= data_shift << step;
        end
    end

    // Clipped pixels still advance the cursor
    assign pixel_write.enable = busy && in_frame;
    assign pixel_write.address = {cursor_y[2:0], cursor_x[3:0]};
    assign pixel_write.index = raw + sprite_config.palette_offset;

    data_while_idle: assert property (
        @(posedge display_clock_in) disable iff (!display_reset_n_in)
        sprite_data_valid |-> !busy
    );

endmodule

//--- logic/frame_buffers.sv
`timescale 1ns/100ps

module frame_buffers (
    input logic display_clock_in,
    input logic display_reset_n_in,
    input graphics_pkg::pixel_write_t pixel_write,
    input graphics_pkg::pixel_address_t read_address,
    input logic swap_request,
    input logic frame_end,
    output graphics_pkg::pixel_index_t read_index
);

    graphics_pkg::pixel_index_t buffer_a [graphics_pkg::pixel_count] = '{default: '0};
    graphics_pkg::pixel_index_t buffer_b [graphics_pkg::pixel_count] = '{default: '0};

    // Low shows buffer_a
    logic front_select;
    logic swap_pending;

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            front_select <= 1'b0;
            swap_pending <= 1'b0;
        end else if (frame_end && swap_pending) begin
            front_select <= !front_select;
            swap_pending <= swap_request;
        end else if (swap_request) begin
            swap_pending <= 1'b1;
        end
    end

    // Sprite writes land in the back buffer
    always_ff @(posedge display_clock_in) begin
        if (pixel_write.enable && front_select) begin
            buffer_a[pixel_write.address] <= pixel_write.index;
        end
        if (pixel_write.enable && !front_select) begin
            buffer_b[pixel_write.address] <= pixel_write.index;
        end
    end

    always_ff @(posedge display_clock_in) begin
        if (front_select) begin
            read_index <= buffer_b[read_address];
        end else begin
            read_index <= buffer_a[read_address];
        end
    end

endmodule

//--- logic/color_palette.sv
`timescale 1ns/100ps

module color_palette (
    input logic display_clock_in,
    input logic display_reset_n_in,
    input graphics_pkg::palette_write_t palette_write,
    input graphics_pkg::pixel_index_t read_index,
    output graphics_pkg::yuv_color_t color
);

    graphics_pkg::yuv_color_t entries [2 ** $bits(graphics_pkg::pixel_index_t)];

    // All entries black out of reset
    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            for (int i = 0; i < $size(entries); i++) begin
                entries[i] <= '0;
            end
        end else if (palette_write.enable) begin
            entries[palette_write.index] <= palette_write.color;
        end
    end

    // Registered lookup
    always_ff @(posedge display_clock_in) begin
        color <= entries[read_index];
    end

endmodule

//--- logic/display_timing.sv
`timescale 1ns/100ps

module display_timing (
    input logic display_clock_in,
    input logic display_reset_n_in,
    input graphics_pkg::yuv_color_t color,
    output graphics_pkg::pixel_address_t read_address,
    output logic frame_end,
    output logic display_hsync_out,
    output logic display_vsync_out,
    output logic [3:0] display_y_out,
    output logic [2:0] display_cb_out,
    output logic [2:0] display_cr_out
);

    typedef enum logic [1:0] {active, horizontal_blank, vertical_blank} sync_state_t;

    typedef struct packed {
        logic active;
        logic hsync;
        logic vsync;
    } scan_flags_t;

    graphics_pkg::coord_t h_count;
    graphics_pkg::coord_t v_count;
    sync_state_t sync_state;
    scan_flags_t flags;
    scan_flags_t flags_d1;
    scan_flags_t flags_d2;

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == graphics_pkg::coord_t'(graphics_pkg::line_total - 1)) begin
            h_count <= '0;
            if (v_count == graphics_pkg::coord_t'(graphics_pkg::frame_total_lines - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 8'd1;
            end
        end else begin
            h_count <= h_count + 8'd1;
        end
    end

    always_comb begin
        if (v_count >= graphics_pkg::coord_t'(graphics_pkg::frame_height)) begin
            sync_state = vertical_blank;
        end else if (h_count >= graphics_pkg::coord_t'(graphics_pkg::frame_width)) begin
            sync_state = horizontal_blank;
        end else begin
            sync_state = active;
        end
    end

    assign read_address = {v_count[2:0], h_count[3:0]};
    assign frame_end = h_count == 8'd0 &&
                       v_count == graphics_pkg::coord_t'(graphics_pkg::frame_height);

    // hsync keeps running through vertical blank
    assign flags.active = sync_state == active;
    assign flags.hsync = h_count >= graphics_pkg::coord_t'(graphics_pkg::frame_width);
    assign flags.vsync = sync_state == vertical_blank;

    // Two stages match the buffer and palette reads
    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            flags_d1 <= '0;
            flags_d2 <= '0;
            display_hsync_out <= 1'b0;
            display_vsync_out <= 1'b0;
            display_y_out <= '0;
            display_cb_out <= '0;
            display_cr_out <= '0;
        end else begin
            flags_d1 <= flags;
            flags_d2 <= flags_d1;
            display_hsync_out <= flags_d2.hsync;
            display_vsync_out <= flags_d2.vsync;
            display_y_out <= flags_d2.active ? color.y : 4'd0;
            display_cb_out <= flags_d2.active ? color.cb : 3'd0;
            display_cr_out <= flags_d2.active ? color.cr : 3'd0;
        end
    end

    // vsync only moves where a new line starts
    vsync_at_line_start: assert property (
        @(posedge display_clock_in) disable iff (!display_reset_n_in)
        $changed(display_vsync_out) |-> $fell(display_hsync_out)
    );

endmodule

//--- logic/graphics.sv
`timescale 1ns/100ps

module graphics (
    input logic display_clock_in,
    input logic display_reset_n_in,
    input graphics_pkg::byte_t op_code_in,
    input logic op_code_valid_in,
    input graphics_pkg::byte_t operand_in,
    input logic operand_valid_in,
    input graphics_pkg::operand_count_t operand_count_in,
    output logic display_hsync_out,
    output logic display_vsync_out,
    output logic [3:0] display_y_out,
    output logic [2:0] display_cb_out,
    output logic [2:0] display_cr_out
);

    graphics_pkg::palette_write_t palette_write;
    graphics_pkg::sprite_config_t sprite_config;
    logic sprite_start;
    graphics_pkg::byte_t sprite_data;
    logic sprite_data_valid;
    logic swap_request;
    graphics_pkg::pixel_write_t pixel_write;
    graphics_pkg::pixel_address_t read_address;
    graphics_pkg::pixel_index_t read_index;
    graphics_pkg::yuv_color_t color;
    logic frame_end;

    command_decoder i_command_decoder (.*);

    sprite_engine i_sprite_engine (
        .display_clock_in,
        .display_reset_n_in,
        .sprite_config,
        .sprite_start,
        .sprite_data,
        .sprite_data_valid,
        .pixel_write,
        .busy()
    );

    frame_buffers i_frame_buffers (.*);

    color_palette i_color_palette (.*);

    display_timing i_display_timing (.*);

endmodule

//--- test/graphics_tb_frames.svh
// Returns at the falling clock edge where vsync has just dropped
task automatic wait_vsync_fall();
    logic previous;
    logic fell;
    fell = 1'b0;
    @(negedge display_clock_in);
    previous = display_vsync_out;
    while (!fell) begin
        @(negedge display_clock_in);
        fell = previous && !display_vsync_out;
        previous = display_vsync_out;
    end
endtask

// Second fall is the first frame sure to show a pending swap
task automatic check_displayed_frame();
    int h;
    int v;
    graphics_pkg::yuv_color_t expected;
    wait_vsync_fall();
    wait_vsync_fall();
    for (int k = 0; k < frame_cycles; k++) begin
        if (k > 0) begin
            @(negedge display_clock_in);
        end
        h = k % graphics_pkg::line_total;
        v = k / graphics_pkg::line_total;
        check_sync($sformatf("hsync,vsync at (%0d,%0d)", h, v),
                   {display_hsync_out, display_vsync_out},
                   {h >= graphics_pkg::frame_width, v >= graphics_pkg::frame_height});
        expected = '0;
        if (h < graphics_pkg::frame_width && v < graphics_pkg::frame_height) begin
            expected = model_palette[model_buffer[model_front][v * 16 + h]];
        end
        check_color($sformatf("color at (%0d,%0d)", h, v),
                    {display_y_out, display_cb_out, display_cr_out}, expected);
    end
endtask

//--- test/graphics_tb.sv
`timescale 1ns/100ps

module graphics_tb;

    // Not a DUT opcode, the row only checks the displayed frame
    localparam graphics_pkg::byte_t check_only = 8'h00;
    localparam int strobe_spacing = 12;
    localparam int frame_cycles = graphics_pkg::line_total * graphics_pkg::frame_total_lines;
    localparam int table_length = 23;

    typedef struct packed {
        graphics_pkg::byte_t op_code;
        logic [3:0] listed;
        logic [7:0][7:0] operands;
        logic [7:0] data_bytes;
    } command_t;

    logic display_clock_in;
    logic display_reset_n_in;
    graphics_pkg::byte_t op_code_in;
    logic op_code_valid_in;
    graphics_pkg::byte_t operand_in;
    logic operand_valid_in;
    graphics_pkg::operand_count_t operand_count_in;
    logic display_hsync_out;
    logic display_vsync_out;
    logic [3:0] display_y_out;
    logic [2:0] display_cb_out;
    logic [2:0] display_cr_out;

    command_t commands [table_length];
    graphics_pkg::yuv_color_t model_palette [16];
    graphics_pkg::pixel_index_t model_buffer [2][graphics_pkg::pixel_count];
    logic model_front;
    int model_cursor_x;
    int model_cursor_y;
    int model_column;
    logic [31:0] lcg_state = 32'hd93a;
    int cycle_count = 0;
    int cycle_limit = 0;
    int error_count = 0;

    graphics i_dut (.*);

    initial begin
        display_clock_in = 1'b0;
        forever #20 display_clock_in = !display_clock_in;
    end

    always @(posedge display_clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_on_error($sformatf("Timeout, the run did not finish in %0d cycles", cycle_limit));
        end
    end

    task automatic stop_on_error(string reason);
        error_count++;
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_color(string name, graphics_pkg::yuv_color_t actual,
                               graphics_pkg::yuv_color_t expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_sync(string name, logic [1:0] actual, logic [1:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    function automatic graphics_pkg::byte_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic command_t make_command(graphics_pkg::byte_t op_code, int listed,
            graphics_pkg::byte_t a, b, c, d, e, int data_bytes);
        command_t row;
        row = '0;
        row.op_code = op_code;
        row.listed = 4'(listed);
        row.operands[0] = a;
        row.operands[1] = b;
        row.operands[2] = c;
        row.operands[3] = d;
        row.operands[4] = e;
        row.data_bytes = 8'(data_bytes);
        return row;
    endfunction

    task automatic build_table();
        graphics_pkg::byte_t index;
        for (int i = 0; i < 16; i++) begin
            index = 8'(i);
            // Distinct colors, entry 0 brightest; low operand bits are don't care
            commands[i] = make_command(graphics_pkg::op_assign_color, 4, index,
                                       {4'(15 - i), 4'h5}, {index[2:0], 5'h0a},
                                       {3'(i + 3), 5'h11}, 8'h00, 0);
        end
        commands[16] = make_command(graphics_pkg::op_draw_sprite, 5, 0, 0, 16, 16, 0, 64);
        commands[17] = make_command(graphics_pkg::op_switch_buffer, 0, 0, 0, 0, 0, 0, 0);
        commands[18] = make_command(graphics_pkg::op_draw_sprite, 5, 2, 1, 5, 2, 9, 3);
        // Offset 14 wraps, and the last four pixels fall below the frame
        commands[19] = make_command(graphics_pkg::op_draw_sprite, 5, 9, 4, 3, 4, 14, 4);
        commands[20] = make_command(graphics_pkg::op_draw_sprite, 5, 12, 6, 8, 16, 3, 8);
        commands[21] = make_command(check_only, 0, 0, 0, 0, 0, 0, 0);
        commands[22] = make_command(graphics_pkg::op_switch_buffer, 0, 0, 0, 0, 0, 0, 0);
    endtask

    // Reset, the first frame check, then every row and its checks
    function automatic int run_length();
        int cycles;
        cycles = 10 + 3 * frame_cycles + 500;
        for (int i = 0; i < table_length; i++) begin
            cycles += (int'(commands[i].listed) + int'(commands[i].data_bytes) + 1) *
                      strobe_spacing + 2;
            if (commands[i].op_code inside {graphics_pkg::op_switch_buffer, check_only}) begin
                cycles += 3 * frame_cycles;
            end
        end
        return cycles;
    endfunction

    task automatic model_sprite_byte(command_t row, graphics_pkg::byte_t data);
        int bits;
        int raw;
        case (row.operands[3])
            8'd4: bits = 2;
            8'd16: bits = 4;
            default: bits = 1;
        endcase
        for (int k = 0; k < 8 / bits; k++) begin
            raw = (int'(data) >> (8 - bits * (k + 1))) & ((1 << bits) - 1);
            if (model_cursor_x < graphics_pkg::frame_width &&
                model_cursor_y < graphics_pkg::frame_height) begin
                model_buffer[!model_front][model_cursor_y * 16 + model_cursor_x] =
                    4'(raw + int'(row.operands[4][3:0]));
            end
            model_column++;
            if (model_column == int'(row.operands[2])) begin
                model_column = 0;
                model_cursor_x = int'(row.operands[0]);
                model_cursor_y++;
            end else begin
                model_cursor_x++;
            end
        end
    endtask

    task automatic send_operand(graphics_pkg::operand_count_t count, graphics_pkg::byte_t data);
        @(posedge display_clock_in);
        operand_in <= data;
        operand_count_in <= count;
        operand_valid_in <= 1'b1;
        @(posedge display_clock_in);
        operand_valid_in <= 1'b0;
        repeat (strobe_spacing - 2) @(posedge display_clock_in);
    endtask

    task automatic apply_command(command_t row);
        graphics_pkg::byte_t data;
        int total;
        total = int'(row.listed) + int'(row.data_bytes);
        model_cursor_x = int'(row.operands[0]);
        model_cursor_y = int'(row.operands[1]);
        model_column = 0;
        @(posedge display_clock_in);
        op_code_in <= row.op_code;
        op_code_valid_in <= 1'b1;
        for (int n = 1; n <= total; n++) begin
            if (n <= int'(row.listed)) begin
                data = row.operands[n - 1];
            end else begin
                data = lcg_next();
                model_sprite_byte(row, data);
            end
            send_operand(8'(n), data);
        end
        @(posedge display_clock_in);
        op_code_valid_in <= 1'b0;
        if (row.op_code == graphics_pkg::op_assign_color) begin
            model_palette[row.operands[0][3:0]] = '{y: row.operands[1][7:4],
                                                   cb: row.operands[2][7:5],
                                                   cr: row.operands[3][7:5]};
        end
        if (row.op_code == graphics_pkg::op_switch_buffer) begin
            model_front = !model_front;
        end
        repeat (strobe_spacing) @(posedge display_clock_in);
    endtask

    `include "graphics_tb_frames.svh"

    initial begin
        display_reset_n_in = 1'b0;
        op_code_in = '0;
        op_code_valid_in = 1'b0;
        operand_in = '0;
        operand_valid_in = 1'b0;
        operand_count_in = '0;
        model_front = 1'b0;
        foreach (model_palette[i]) model_palette[i] = '0;
        foreach (model_buffer[b, a]) model_buffer[b][a] = '0;
        build_table();
        cycle_limit = run_length();
        repeat (10) @(posedge display_clock_in);
        display_reset_n_in <= 1'b1;
        // Blank palette and buffers after reset
        check_displayed_frame();
        foreach (commands[i]) begin
            if (commands[i].op_code != check_only) begin
                apply_command(commands[i]);
            end
            if (commands[i].op_code inside {graphics_pkg::op_switch_buffer, check_only}) begin
                check_displayed_frame();
            end
        end
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+test
logic/graphics_pkg.sv
logic/command_decoder.sv
logic/sprite_engine.sv
logic/frame_buffers.sv
logic/color_palette.sv
logic/display_timing.sv
logic/graphics.sv
test/graphics_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --timing --assert
TOP = graphics_tb
FLIST = flist.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_TEXT = All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
